// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbDecodeExecute \
		-f decodeExecute.f -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire logic [6:0]       opcode,
    output rv32Pkg::aluSrc1E      aluSrc1,
    output rv32Pkg::aluSrc2E      aluSrc2,
    output rv32Pkg::aluOpE        aluOp,
    output logic                  memWrite,
    output logic                  memRead,
    output logic                  regWrite,
    output logic                  memToReg,
    output logic                  illegal
);

    always_comb begin
        // defaults equal a bubble
        aluSrc1  = rv32Pkg::src1Rs1;
        aluSrc2  = rv32Pkg::src2Rs2;
        aluOp    = rv32Pkg::aluAdd;
        memWrite = 1'b0;
        memRead  = 1'b0;
        regWrite = 1'b0;
        memToReg = 1'b0;
        illegal  = 1'b0;
        case (rv32Pkg::opcodeE'(opcode))
            rv32Pkg::opRtype: begin
                aluOp    = rv32Pkg::aluRtype;
                regWrite = 1'b1;
            end
            rv32Pkg::opItype: begin
                aluSrc2  = rv32Pkg::src2ImmI;
                aluOp    = rv32Pkg::aluItype;
                regWrite = 1'b1;
            end
            rv32Pkg::opLoad: begin
                aluSrc2  = rv32Pkg::src2ImmI;
                memRead  = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            rv32Pkg::opStore: begin
                aluSrc2  = rv32Pkg::src2ImmS;
                memWrite = 1'b1;
            end
            rv32Pkg::opLui: begin
                // zero operand A so the adder passes immU through
                aluSrc1  = rv32Pkg::src1Zero;
                aluSrc2  = rv32Pkg::src2ImmU;
                aluOp    = rv32Pkg::aluPassB;
                regWrite = 1'b1;
            end
            rv32Pkg::opAuipc: begin
                aluSrc1  = rv32Pkg::src1Pc;
                aluSrc2  = rv32Pkg::src2ImmU;
                regWrite = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decodeExecute.f ====
rv32Pkg.sv
registerFile.sv
controlUnit.sv
immediateGenerator.sv
idExRegister.sv
executeUnit.sv
decodeExecuteTop.sv
tbDecodeExecute.sv

// ==== decodeExecuteStimulus.txt ====
// id wbEn wbRd wbData | instrValid flush instr pc | expected: exValid ctrl(rw mw mr m2r)
// aluResult storeData exRd illegalInstr (all hex, one test per line, x1..x3 preloaded)
00 0 00 00000000 0 0 00000000 00000000 0 0 00000000 00000000 00 0
01 1 01 80000010 0 0 00000000 00000000 0 0 00000000 00000000 00 0
02 1 02 00000034 0 0 00000000 00000000 0 0 00000000 00000000 00 0
03 1 03 00001000 0 0 00000000 00000000 0 0 00000000 00000000 00 0
04 1 00 deadbeef 0 0 00000000 00000000 0 0 00000000 00000000 00 0
05 0 00 00000000 1 0 002082b3 00000100 1 8 80000044 00000034 05 0
06 0 00 00000000 1 0 402082b3 00000104 1 8 7fffffdc 00000034 05 0
07 0 00 00000000 1 0 002092b3 00000108 1 8 01000000 00000034 05 0
08 0 00 00000000 1 0 0020a2b3 0000010c 1 8 00000001 00000034 05 0
09 0 00 00000000 1 0 0020b2b3 00000110 1 8 00000000 00000034 05 0
0a 0 00 00000000 1 0 0020c2b3 00000114 1 8 80000024 00000034 05 0
0b 0 00 00000000 1 0 0020d2b3 00000118 1 8 00000800 00000034 05 0
0c 0 00 00000000 1 0 4020d2b3 0000011c 1 8 fffff800 00000034 05 0
0d 0 00 00000000 1 0 0020e2b3 00000120 1 8 80000034 00000034 05 0
0e 0 00 00000000 1 0 0020f2b3 00000124 1 8 00000010 00000034 05 0
0f 0 00 00000000 1 0 ff808313 00000128 1 8 80000008 00000000 06 0
10 0 00 00000000 1 0 4080d393 0000012c 1 8 ff800000 00000000 07 0
11 0 00 00000000 1 0 123454b7 00000130 1 8 12345000 00001000 09 0
12 0 00 00000000 1 0 00001517 00000134 1 8 00001134 00000000 0a 0
13 0 00 00000000 1 0 0101a583 00000138 1 b 00001010 00000000 0b 0
14 0 00 00000000 1 0 fe21ae23 0000013c 1 4 00000ffc 00000034 1c 0
15 0 00 00000000 1 1 002082b3 00000140 0 0 00000000 00000000 00 0
16 0 00 00000000 1 0 0000007f 00000144 0 0 00000000 00000000 00 1
17 0 00 00000000 1 0 00200433 00000148 1 8 00000034 00000034 08 0

// ==== decodeExecuteTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteTop #(
    parameter int regCount = 32
) (
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      instrValid,
    input  wire logic [31:0]               instr,
    input  wire logic [31:0]               pc,
    input  wire logic                      flush,
    input  wire logic                      wbEn,
    input  wire logic [4:0]                wbRd,
    input  wire logic [rv32Pkg::xlen-1:0]  wbData,
    output logic                           exValid,
    output logic      [rv32Pkg::xlen-1:0]  aluResult,
    output logic      [rv32Pkg::xlen-1:0]  storeData,
    output logic      [4:0]                exRd,
    output logic                           exRegWrite,
    output logic                           exMemWrite,
    output logic                           exMemRead,
    output logic                           exMemToReg,
    output logic                           illegalInstr
);

    logic [rv32Pkg::xlen-1:0] rs1Data, rs2Data, immI, immS, immU;
    rv32Pkg::aluSrc1E decSrc1, idSrc1;
    rv32Pkg::aluSrc2E decSrc2, idSrc2;
    rv32Pkg::aluOpE   decAluOp, idAluOp;
    logic decMemWrite, decMemRead, decRegWrite, decMemToReg, decIllegal;
    logic idValid, idMemWrite, idMemRead, idRegWrite, idMemToReg;
    logic [31:0] idPc;
    logic [2:0] idFunc3;
    logic [6:0] idFunc7;
    logic [rv32Pkg::xlen-1:0] idRead1, idRead2, idImmI, idImmS, idImmU;
    logic [4:0] idRd, idRs1, idRs2;

    // illegal opcodes only flag while a real instruction is present
    assign illegalInstr = instrValid & decIllegal;

    registerFile #(.regCount(regCount)) regFile (
        .clk(clk), .arstN(arstN), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    controlUnit ctrl (
        .opcode(instr[6:0]), .aluSrc1(decSrc1), .aluSrc2(decSrc2), .aluOp(decAluOp),
        .memWrite(decMemWrite), .memRead(decMemRead), .regWrite(decRegWrite),
        .memToReg(decMemToReg), .illegal(decIllegal)
    );

    immediateGenerator immGen (.instr(instr), .immI(immI), .immS(immS), .immU(immU));

    idExRegister idEx (
        .clk(clk), .arstN(arstN), .flush(flush), .validIn(instrValid & ~decIllegal),
        .pcIn(pc), .aluSrc1In(decSrc1), .aluSrc2In(decSrc2), .aluOpIn(decAluOp),
        .memWriteIn(decMemWrite), .memReadIn(decMemRead), .regWriteIn(decRegWrite),
        .memToRegIn(decMemToReg), .func3In(instr[14:12]), .func7In(instr[31:25]),
        .read1In(rs1Data), .read2In(rs2Data), .immIIn(immI), .immSIn(immS), .immUIn(immU),
        .rdIn(instr[11:7]), .rs1In(instr[19:15]), .rs2In(instr[24:20]),
        .validOut(idValid), .pcOut(idPc), .aluSrc1Out(idSrc1), .aluSrc2Out(idSrc2),
        .aluOpOut(idAluOp), .memWriteOut(idMemWrite), .memReadOut(idMemRead),
        .regWriteOut(idRegWrite), .memToRegOut(idMemToReg), .func3Out(idFunc3),
        .func7Out(idFunc7), .read1Out(idRead1), .read2Out(idRead2), .immIOut(idImmI),
        .immSOut(idImmS), .immUOut(idImmU), .rdOut(idRd), .rs1Out(idRs1), .rs2Out(idRs2)
    );

    executeUnit exec (
        .clk(clk), .arstN(arstN), .valid(idValid), .pc(idPc), .aluSrc1(idSrc1),
        .aluSrc2(idSrc2), .aluOp(idAluOp), .memWrite(idMemWrite), .memRead(idMemRead),
        .regWrite(idRegWrite), .memToReg(idMemToReg), .func3(idFunc3), .func7(idFunc7),
        .read1(idRead1), .read2(idRead2), .immI(idImmI), .immS(idImmS), .immU(idImmU),
        .rd(idRd), .rs1(idRs1), .rs2(idRs2), .exValid(exValid), .aluResult(aluResult),
        .storeData(storeData), .exRd(exRd), .exRegWrite(exRegWrite),
        .exMemWrite(exMemWrite), .exMemRead(exMemRead), .exMemToReg(exMemToReg)
    );

endmodule

`default_nettype wire

// ==== executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      valid,
    input  wire logic [31:0]               pc,
    input  wire rv32Pkg::aluSrc1E          aluSrc1,
    input  wire rv32Pkg::aluSrc2E          aluSrc2,
    input  wire rv32Pkg::aluOpE            aluOp,
    input  wire logic                      memWrite,
    input  wire logic                      memRead,
    input  wire logic                      regWrite,
    input  wire logic                      memToReg,
    input  wire logic [2:0]                func3,
    input  wire logic [6:0]                func7,
    input  wire logic [rv32Pkg::xlen-1:0]  read1,
    input  wire logic [rv32Pkg::xlen-1:0]  read2,
    input  wire logic [rv32Pkg::xlen-1:0]  immI,
    input  wire logic [rv32Pkg::xlen-1:0]  immS,
    input  wire logic [rv32Pkg::xlen-1:0]  immU,
    input  wire logic [4:0]                rd,
    input  wire logic [4:0]                rs1,
    input  wire logic [4:0]                rs2,
    output logic                           exValid,
    output logic      [rv32Pkg::xlen-1:0]  aluResult,
    output logic      [rv32Pkg::xlen-1:0]  storeData,
    output logic      [4:0]                exRd,
    output logic                           exRegWrite,
    output logic                           exMemWrite,
    output logic                           exMemRead,
    output logic                           exMemToReg
);

    logic [rv32Pkg::xlen-1:0] opA;
    logic [rv32Pkg::xlen-1:0] opB;
    logic [rv32Pkg::xlen-1:0] result;
    logic [4:0]               shamt;
    rv32Pkg::aluFuncE         aluFunc;

    always_comb begin
        case (aluSrc1)
            rv32Pkg::src1Rs1: opA = read1;
            rv32Pkg::src1Pc:  opA = pc;
            default:          opA = '0;
        endcase
        case (aluSrc2)
            rv32Pkg::src2ImmI: opB = immI;
            rv32Pkg::src2ImmS: opB = immS;
            rv32Pkg::src2ImmU: opB = immU;
            default:           opB = read2;
        endcase
    end

    // LUI reaches here as passB with operand A forced to zero
    always_comb begin
        aluFunc = rv32Pkg::fnAdd;
        if (aluOp == rv32Pkg::aluRtype || aluOp == rv32Pkg::aluItype) begin
            case (func3)
                3'b000: begin
                    // SUB only exists in R-type
                    if (aluOp == rv32Pkg::aluRtype && func7[5]) begin
                        aluFunc = rv32Pkg::fnSub;
                    end
                end
                3'b001: aluFunc = rv32Pkg::fnSll;
                3'b010: aluFunc = rv32Pkg::fnSlt;
                3'b011: aluFunc = rv32Pkg::fnSltu;
                3'b100: aluFunc = rv32Pkg::fnXor;
                3'b101: aluFunc = func7[5] ? rv32Pkg::fnSra : rv32Pkg::fnSrl;
                3'b110: aluFunc = rv32Pkg::fnOr;
                default: aluFunc = rv32Pkg::fnAnd;
            endcase
        end
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (aluFunc)
            rv32Pkg::fnSub:  result = opA - opB;
            rv32Pkg::fnSll:  result = opA << shamt;
            rv32Pkg::fnSlt:  result = {{(rv32Pkg::xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            rv32Pkg::fnSltu: result = {{(rv32Pkg::xlen-1){1'b0}}, opA < opB};
            rv32Pkg::fnXor:  result = opA ^ opB;
            rv32Pkg::fnSrl:  result = opA >> shamt;
            rv32Pkg::fnSra:  result = $unsigned($signed(opA) >>> shamt);
            rv32Pkg::fnOr:   result = opA | opB;
            rv32Pkg::fnAnd:  result = opA & opB;
            default:         result = opA + opB;
        endcase
    end

    // controls already zeroed upstream for bubbles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemToReg <= 1'b0;
        end else begin
            exValid    <= valid;
            exRegWrite <= regWrite;
            exMemWrite <= memWrite;
            exMemRead  <= memRead;
            exMemToReg <= memToReg;
        end
    end

    always_ff @(posedge clk) begin
        aluResult <= result;
        storeData <= read2;
        exRd      <= rd;
    end

    writesNeedValid: assert property (@(posedge clk) disable iff (!arstN)
        (exRegWrite || exMemWrite || exMemRead) |-> exValid);

    // x0 operands arrive as zero through the regfile and ID/EX
    x0OperandZero: assert property (@(posedge clk) disable iff (!arstN)
        valid |-> ((rs1 != '0 || read1 == '0) && (rs2 != '0 || read2 == '0)));

endmodule

`default_nettype wire

// ==== idExRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

module idExRegister (
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      flush,
    input  wire logic                      validIn,
    input  wire logic [31:0]               pcIn,
    input  wire rv32Pkg::aluSrc1E          aluSrc1In,
    input  wire rv32Pkg::aluSrc2E          aluSrc2In,
    input  wire rv32Pkg::aluOpE            aluOpIn,
    input  wire logic                      memWriteIn,
    input  wire logic                      memReadIn,
    input  wire logic                      regWriteIn,
    input  wire logic                      memToRegIn,
    input  wire logic [2:0]                func3In,
    input  wire logic [6:0]                func7In,
    input  wire logic [rv32Pkg::xlen-1:0]  read1In,
    input  wire logic [rv32Pkg::xlen-1:0]  read2In,
    input  wire logic [rv32Pkg::xlen-1:0]  immIIn,
    input  wire logic [rv32Pkg::xlen-1:0]  immSIn,
    input  wire logic [rv32Pkg::xlen-1:0]  immUIn,
    input  wire logic [4:0]                rdIn,
    input  wire logic [4:0]                rs1In,
    input  wire logic [4:0]                rs2In,
    output logic                           validOut,
    output logic      [31:0]               pcOut,
    output rv32Pkg::aluSrc1E               aluSrc1Out,
    output rv32Pkg::aluSrc2E               aluSrc2Out,
    output rv32Pkg::aluOpE                 aluOpOut,
    output logic                           memWriteOut,
    output logic                           memReadOut,
    output logic                           regWriteOut,
    output logic                           memToRegOut,
    output logic      [2:0]                func3Out,
    output logic      [6:0]                func7Out,
    output logic      [rv32Pkg::xlen-1:0]  read1Out,
    output logic      [rv32Pkg::xlen-1:0]  read2Out,
    output logic      [rv32Pkg::xlen-1:0]  immIOut,
    output logic      [rv32Pkg::xlen-1:0]  immSOut,
    output logic      [rv32Pkg::xlen-1:0]  immUOut,
    output logic      [4:0]                rdOut,
    output logic      [4:0]                rs1Out,
    output logic      [4:0]                rs2Out
);

    // valid and side-effect controls clear for a flushed or empty slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validOut    <= 1'b0;
            memWriteOut <= 1'b0;
            memReadOut  <= 1'b0;
            regWriteOut <= 1'b0;
            memToRegOut <= 1'b0;
        end else if (flush || !validIn) begin
            validOut    <= 1'b0;
            memWriteOut <= 1'b0;
            memReadOut  <= 1'b0;
            regWriteOut <= 1'b0;
            memToRegOut <= 1'b0;
        end else begin
            validOut    <= 1'b1;
            memWriteOut <= memWriteIn;
            memReadOut  <= memReadIn;
            regWriteOut <= regWriteIn;
            memToRegOut <= memToRegIn;
        end
    end

    // payload loads every cycle
    always_ff @(posedge clk) begin
        pcOut      <= pcIn;
        aluSrc1Out <= aluSrc1In;
        aluSrc2Out <= aluSrc2In;
        aluOpOut   <= aluOpIn;
        func3Out   <= func3In;
        func7Out   <= func7In;
        read1Out   <= read1In;
        read2Out   <= read2In;
        immIOut    <= immIIn;
        immSOut    <= immSIn;
        immUOut    <= immUIn;
        rdOut      <= rdIn;
        rs1Out     <= rs1In;
        rs2Out     <= rs2In;
    end

    // decode never asks for a load and a store at once
    noLoadStore: assert property (@(posedge clk) disable iff (!arstN)
        !(memReadOut && memWriteOut));

endmodule

`default_nettype wire

// ==== immediateGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediateGenerator (
    input  wire logic [31:0]              instr,
    output logic      [rv32Pkg::xlen-1:0] immI,
    output logic      [rv32Pkg::xlen-1:0] immS,
    output logic      [rv32Pkg::xlen-1:0] immU
);

    logic signBit;

    // bit 31 is the sign for every format
    assign signBit = instr[31];

    // loads, ALU immediates and shifts
    assign immI = {{20{signBit}}, instr[31:20]};

    // stores split the offset around rs2
    assign immS = {{20{signBit}}, instr[31:25], instr[11:7]};

    // LUI and AUIPC, low twelve bits zero
    assign immU = {instr[31:12], 12'b0};

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
    parameter int regCount = 32
) (
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      wbEn,
    input  wire logic [4:0]                wbRd,
    input  wire logic [rv32Pkg::xlen-1:0]  wbData,
    input  wire logic [4:0]                rs1Addr,
    input  wire logic [4:0]                rs2Addr,
    output logic      [rv32Pkg::xlen-1:0]  rs1Data,
    output logic      [rv32Pkg::xlen-1:0]  rs2Data
);

    localparam int idxW = $clog2(regCount);

    logic [rv32Pkg::xlen-1:0] regs [regCount];
    logic [idxW-1:0] wbIdx;
    logic [idxW-1:0] rs1Idx;
    logic [idxW-1:0] rs2Idx;

    // upper index bits dropped, so RV32E wraps x16..x31 onto x0..x15
    assign wbIdx  = wbRd[idxW-1:0];
    assign rs1Idx = rs1Addr[idxW-1:0];
    assign rs2Idx = rs2Addr[idxW-1:0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbIdx != '0)) begin
            regs[wbIdx] <= wbData;
        end
    end

    // no write bypass, same-cycle read sees the old word
    assign rs1Data = regs[rs1Idx];
    assign rs2Data = regs[rs2Idx];

    x0StaysZero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0);

endmodule

`default_nettype wire

// ==== rv32Pkg.sv ====
`default_nettype none

package rv32Pkg;

    // RV32 fixes the integer data width
    parameter int unsigned xlen = 32;

    // major opcodes handled by this slice
    typedef enum logic [6:0] {
        opRtype = 7'b0110011,
        opItype = 7'b0010011,
        opLoad  = 7'b0000011,
        opStore = 7'b0100011,
        opLui   = 7'b0110111,
        opAuipc = 7'b0010111
    } opcodeE;

    // coarse ALU class from decode, refined in execute by func3/func7
    typedef enum logic [1:0] {
        aluAdd   = 2'd0,
        aluRtype = 2'd1,
        aluItype = 2'd2,
        aluPassB = 2'd3
    } aluOpE;

    typedef enum logic [1:0] {
        src1Rs1  = 2'd0,
        src1Pc   = 2'd1,
        src1Zero = 2'd2
    } aluSrc1E;

    typedef enum logic [1:0] {
        src2Rs2  = 2'd0,
        src2ImmI = 2'd1,
        src2ImmS = 2'd2,
        src2ImmU = 2'd3
    } aluSrc2E;

    typedef enum logic [3:0] {
        fnAdd, fnSub, fnSll, fnSlt, fnSltu,
        fnXor, fnSrl, fnSra, fnOr, fnAnd
    } aluFuncE;

endpackage

`default_nettype wire

// ==== tbDecodeExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDecodeExecute;

    localparam int numTests   = 24;
    localparam int fieldCount = 14;
    localparam int clkPeriod  = 100;

    logic                     clk;
    logic                     arstN;
    logic                     instrValid;
    logic [31:0]              instr;
    logic [31:0]              pc;
    logic                     flush;
    logic                     wbEn;
    logic [4:0]               wbRd;
    logic [rv32Pkg::xlen-1:0] wbData;
    logic                     exValid;
    logic [rv32Pkg::xlen-1:0] aluResult;
    logic [rv32Pkg::xlen-1:0] storeData;
    logic [4:0]               exRd;
    logic                     exRegWrite;
    logic                     exMemWrite;
    logic                     exMemRead;
    logic                     exMemToReg;
    logic                     illegalInstr;

    // one row per test, fieldCount words per row
    logic [31:0] stim [numTests*fieldCount];
    int          testErrors [numTests];
    int          pending [$];
    int          passCount;
    int          failCount;
    string       testNames [numTests] = '{
        "reset", "preload x1", "preload x2", "preload x3", "write x0",
        "add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or", "and",
        "addi", "srai", "lui", "auipc", "load", "store", "flushed", "illegal", "read x0"
    };

    decodeExecuteTop #(.regCount(32)) DUT (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .pc(pc),
        .flush(flush), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData), .exValid(exValid),
        .aluResult(aluResult), .storeData(storeData), .exRd(exRd),
        .exRegWrite(exRegWrite), .exMemWrite(exMemWrite), .exMemRead(exMemRead),
        .exMemToReg(exMemToReg), .illegalInstr(illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod/2) clk = ~clk;
    end

    // reset, all tests and some slack
    initial begin
        #((numTests + 20) * clkPeriod);
        $display("timeout: the pipeline did not finish all tests in time");
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] stimField(input int t, input int col);
        return stim[t*fieldCount + col];
    endfunction

    function automatic string nameOf(input int t);
        int id;
        id = int'(stimField(t, 0));
        return testNames[id];
    endfunction

    task automatic checkWord(input int t, input string what,
                             input logic [rv32Pkg::xlen-1:0] expected,
                             input logic [rv32Pkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", nameOf(t), what, expected, actual);
            testErrors[t]++;
        end
    endtask

    task automatic checkReg(input int t, input logic [4:0] expected, input logic [4:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s exRd: expected x%0d, actual x%0d", nameOf(t), expected, actual);
            testErrors[t]++;
        end
    endtask

    // regWrite, memWrite, memRead, memToReg
    task automatic checkCtrl(input int t, input logic [3:0] expected, input logic [3:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s controls: expected %b, actual %b", nameOf(t), expected, actual);
            testErrors[t]++;
        end
    endtask

    task automatic checkFlag(input int t, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %b, actual %b", nameOf(t), what, expected, actual);
            testErrors[t]++;
        end
    endtask

    task automatic driveIdle();
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        flush      = 1'b0;
        wbEn       = 1'b0;
        wbRd       = '0;
        wbData     = '0;
    endtask

    task automatic driveLine(input int t);
        logic [31:0] w;
        w          = stimField(t, 1);
        wbEn       = w[0];
        w          = stimField(t, 2);
        wbRd       = w[4:0];
        wbData     = stimField(t, 3);
        w          = stimField(t, 4);
        instrValid = w[0];
        w          = stimField(t, 5);
        flush      = w[0];
        instr      = stimField(t, 6);
        pc         = stimField(t, 7);
    endtask

    task automatic checkOutputs(input int t);
        logic [31:0] w;
        logic        expValid;
        logic [3:0]  expCtrl;
        w        = stimField(t, 8);
        expValid = w[0];
        w        = stimField(t, 9);
        expCtrl  = w[3:0];
        checkFlag(t, "exValid", expValid, exValid);
        checkCtrl(t, expCtrl, {exRegWrite, exMemWrite, exMemRead, exMemToReg});
        // data fields of a bubble are don't care
        if (expValid) begin
            checkWord(t, "aluResult", stimField(t, 10), aluResult);
            checkWord(t, "storeData", stimField(t, 11), storeData);
            w = stimField(t, 12);
            checkReg(t, w[4:0], exRd);
        end
        if (testErrors[t] == 0) begin
            passCount++;
            $display("test %0d %s: ok", t, nameOf(t));
        end else begin
            failCount++;
            $display("test %0d %s: %0d mismatches", t, nameOf(t), testErrors[t]);
        end
    endtask

    initial begin
        logic [31:0] w;
        passCount = 0;
        failCount = 0;
        arstN     = 1'b0;
        driveIdle();
        $readmemh("decodeExecuteStimulus.txt", stim);
        repeat (8) @(posedge clk);
        #5;
        arstN = 1'b1;
        for (int i = 0; i < numTests + 2; i++) begin
            @(posedge clk);
            #5;
            // results show two edges after the drive
            if (pending.size() > 0 && pending[0] == i - 2) begin
                checkOutputs(pending.pop_front());
            end
            if (i < numTests) begin
                driveLine(i);
                pending.push_back(i);
                #1;
                w = stimField(i, 13);
                checkFlag(i, "illegalInstr", w[0], illegalInstr);
            end else begin
                driveIdle();
            end
        end
        $display("tests %0d, passed %0d, failed %0d", numTests, passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
